// ==== hw/spi_mux_pkg.sv ====
`default_nettype none

package spi_mux_pkg;

  //////////////////////////////
  // frame geometry

  localparam int FRAME_BITS  = 16;  // address byte then value byte
  localparam int N_PERIPH    = 8;   // select lanes behind the mux
  localparam int SYNC_STAGES = 2;   // flops per pin before edge detect

  // counter must hold one bit past a full frame for overrun
  localparam int CNT_W = $clog2(FRAME_BITS + 2);

  //////////////////////////////
  // basic vectors

  typedef logic [FRAME_BITS-1:0] spi_word_t;   // mosi shift word
  typedef logic [7:0]            reg_addr_t;   // high byte of a special frame
  typedef logic [7:0]            reg_data_t;   // low byte of a special frame
  typedef logic [N_PERIPH-1:0]   periph_vec_t; // one bit per peripheral lane
  typedef logic [CNT_W-1:0]      bit_cnt_t;    // bits clocked in this frame

  // dac control bits
  //   [0] ldac
  //   [1] reset
  //   [2] uni/bip a
  //   [3] uni/bip b
  typedef logic [3:0] dac_ctrl_t;

  //////////////////////////////
  // register map

  localparam reg_addr_t ADDR_LED = 8'd7;
  localparam reg_addr_t ADDR_MUX = 8'd8;
  localparam reg_addr_t ADDR_DAC = 8'd9;

  //////////////////////////////
  // frame and shifter types

  // decoded write request, same bit order as the wire
  typedef struct packed {
    reg_addr_t addr;  // sent first
    reg_data_t data;
  } reg_frame_t;

  typedef enum logic [1:0] {
    st_idle,     // no special frame in progress
    st_shift,    // clocking a special frame
    st_overrun   // too many bits, frame is dropped
  } shift_state_t;

endpackage

`default_nettype wire

// ==== hw/spi_frame_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_frame_shifter (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    sck,
  input  logic                    cs_n,
  input  logic                    mosi,
  input  logic                    special_n,
  input  spi_mux_pkg::reg_data_t  rd_data,
  output logic                    rd_req,
  output spi_mux_pkg::reg_addr_t  rd_addr,
  output logic                    wr_en,
  output spi_mux_pkg::reg_frame_t wr_frame,
  output logic                    spi_dout
);

  import spi_mux_pkg::*;

  //////////////////////////////
  // pin synchronizers

  logic [SYNC_STAGES-1:0] sck_sync;
  logic [SYNC_STAGES-1:0] cs_sync;
  logic [SYNC_STAGES-1:0] mosi_sync;
  logic [SYNC_STAGES-1:0] spec_sync;
  logic                   sck_s;
  logic                   cs_s;
  logic                   mosi_s;
  logic                   spec_s;
  logic                   sck_q;    // previous synced sck
  logic                   cs_q;     // previous synced cs_n
  logic                   sck_rise;
  logic                   sck_fall;
  logic                   cs_fall;
  logic                   cs_rise;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      sck_sync  <= '0;
      cs_sync   <= '1;  // deselected
      mosi_sync <= '0;
      spec_sync <= '1;
      sck_q     <= 1'b0;
      cs_q      <= 1'b1;
    end
    else
    begin
      sck_sync  <= {sck_sync[SYNC_STAGES-2:0], sck};
      cs_sync   <= {cs_sync[SYNC_STAGES-2:0], cs_n};
      mosi_sync <= {mosi_sync[SYNC_STAGES-2:0], mosi};
      spec_sync <= {spec_sync[SYNC_STAGES-2:0], special_n};
      sck_q     <= sck_s;
      cs_q      <= cs_s;
    end
  end

  assign sck_s  = sck_sync[SYNC_STAGES-1];
  assign cs_s   = cs_sync[SYNC_STAGES-1];
  assign mosi_s = mosi_sync[SYNC_STAGES-1];  // same delay as sck, so sampled in step
  assign spec_s = spec_sync[SYNC_STAGES-1];

  assign sck_rise = sck_s & ~sck_q;
  assign sck_fall = ~sck_s & sck_q;
  assign cs_fall  = ~cs_s & cs_q;
  assign cs_rise  = cs_s & ~cs_q;

  //////////////////////////////
  // frame fsm

  shift_state_t state;
  bit_cnt_t     bit_cnt;
  spi_word_t    in_sr;    // mosi bits, msb first
  reg_data_t    out_sr;   // read data going out on miso
  logic         rd_load;  // rd_data valid this cycle

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state   <= st_idle;
      bit_cnt <= '0;
      rd_req  <= 1'b0;
      wr_en   <= 1'b0;
    end
    else
    begin
      rd_req <= 1'b0;  // strobes
      wr_en  <= 1'b0;
      if (cs_fall)
      begin
        bit_cnt <= '0;
        // special_n sampled through the same delay as cs_n
        state   <= spec_s ? st_idle : st_shift;
      end
      else
      begin
        case (state)
          st_shift:
          begin
            if (cs_rise)
            begin
              wr_en <= (bit_cnt == bit_cnt_t'(FRAME_BITS));  // exact length only
              state <= st_idle;
            end
            else if (sck_rise)
            begin
              bit_cnt <= bit_cnt + 1'b1;
              if (bit_cnt == bit_cnt_t'(FRAME_BITS))
                state <= st_overrun;  // 17th bit
              rd_req <= (bit_cnt == bit_cnt_t'(FRAME_BITS / 2 - 1));  // 8th bit
            end
          end
          st_overrun:
          begin
            if (cs_rise)
              state <= st_idle;  // frame dropped, no write
          end
          default:
          begin
            state <= st_idle;  // normal frames pass by
          end
        endcase
      end
    end
  end

  // payload shifter
  always_ff @(posedge clk)
  begin
    if (state == st_shift && sck_rise && !cs_fall && bit_cnt < bit_cnt_t'(FRAME_BITS))
      in_sr <= {in_sr[FRAME_BITS-2:0], mosi_s};
  end

  // address is the low byte of in_sr right after the 8th shift
  assign rd_addr  = reg_addr_t'(in_sr[$bits(reg_addr_t)-1:0]);
  // in_sr is frozen from the last sck rise until the next cs fall
  assign wr_frame = reg_frame_t'(in_sr);

  //////////////////////////////
  // miso side

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      rd_load <= 1'b0;
      out_sr  <= '0;
    end
    else
    begin
      rd_load <= rd_req;  // bank answers one cycle after rd_req
      if (cs_fall)
        out_sr <= '0;  // zeros during the address byte
      else if (rd_load)
        out_sr <= rd_data;
      // fall after bit 8 is skipped so the msb holds through the bit 9 rise
      else if (sck_fall && state == st_shift && bit_cnt > bit_cnt_t'(FRAME_BITS / 2))
        out_sr <= {out_sr[$bits(reg_data_t)-2:0], 1'b0};
    end
  end

  assign spi_dout = out_sr[$bits(reg_data_t)-1];

  //////////////////////////////
  // checks

  // a read strobe is bound to an sck rise, a write strobe to a cs rise
  a_no_rd_wr_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    !(rd_req && wr_en));

  a_wr_exact_len: assert property (@(posedge clk) disable iff (!rst_n)
    wr_en |-> $past(state == st_shift) && bit_cnt == bit_cnt_t'(FRAME_BITS));

endmodule

`default_nettype wire

// ==== hw/reg_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_bank (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     rd_req,
  input  logic                     wr_en,
  input  spi_mux_pkg::reg_addr_t   rd_addr,
  input  spi_mux_pkg::reg_frame_t  wr_frame,
  output spi_mux_pkg::reg_data_t   rd_data,
  output spi_mux_pkg::periph_vec_t mux_sel,
  output spi_mux_pkg::reg_data_t   led,
  output spi_mux_pkg::dac_ctrl_t   dac_ctrl
);

  import spi_mux_pkg::*;

  //////////////////////////////
  // write side

  // one commit per exact-length special frame
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      mux_sel  <= '0;  // all peripherals deselected
      led      <= '0;
      dac_ctrl <= '0;
    end
    else if (wr_en)
    begin
      case (wr_frame.addr)
        ADDR_LED:
        begin
          led <= wr_frame.data;
        end
        ADDR_MUX:
        begin
          mux_sel <= periph_vec_t'(wr_frame.data);
        end
        ADDR_DAC:
        begin
          // only ldac, reset and the two uni/bip bits exist
          dac_ctrl <= dac_ctrl_t'(wr_frame.data[$bits(dac_ctrl_t)-1:0]);
        end
        default:
        begin
          // unknown address, nothing stored
        end
      endcase
    end
  end

  //////////////////////////////
  // read side

  reg_data_t rd_mux;

  always_comb
  begin
    case (rd_addr)
      ADDR_LED: rd_mux = led;
      ADDR_MUX: rd_mux = reg_data_t'(mux_sel);
      ADDR_DAC: rd_mux = reg_data_t'(dac_ctrl);  // zero extended
      default:  rd_mux = '0;                     // unmapped reads as zero
    endcase
  end

  // captured once per frame, held while the shifter sends it out
  always_ff @(posedge clk)
  begin
    if (rd_req)
      rd_data <= rd_mux;
  end

  //////////////////////////////
  // checks

  // registers move only as the result of a committed write
  a_reg_change_after_wr: assert property (@(posedge clk) disable iff (!rst_n)
    !$stable({mux_sel, led, dac_ctrl}) |-> $past(wr_en));

endmodule

`default_nettype wire

// ==== hw/periph_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module periph_router (
  input  logic                     cs_n,
  input  logic                     special_n,
  input  logic                     sck,
  input  logic                     mosi,
  input  logic                     spi_dout,
  input  spi_mux_pkg::periph_vec_t mux_sel,
  input  spi_mux_pkg::periph_vec_t periph_miso,
  output spi_mux_pkg::periph_vec_t periph_cs_n,
  output logic                     periph_sck,
  output logic                     periph_mosi,
  output logic                     miso
);

  //////////////////////////////
  // select fan-out

  // purely combinational, pin to pin with no clk delay
  spi_mux_pkg::periph_vec_t sel_n;       // selects for a normal frame
  spi_mux_pkg::periph_vec_t miso_masked;
  logic                     periph_any;  // or of enabled peripherals

  // lane is selected only if enabled in mux and cs_n is low
  assign sel_n = cs_n ? '1 : ~mux_sel;

  // disabled lanes may float or drive garbage, masked off here
  assign miso_masked = periph_miso & mux_sel;
  assign periph_any  = |miso_masked;

  always_comb
  begin
    if (!special_n)
    begin
      periph_cs_n = '1;        // register frame, keep peripherals out
      miso        = spi_dout;  // register bank answers
    end
    else
    begin
      periph_cs_n = sel_n;
      miso        = periph_any;
    end
  end

  //////////////////////////////
  // shared clock and data

  // sck and mosi go to every lane, the select decides who listens
  assign periph_sck  = sck;
  assign periph_mosi = mosi;

endmodule

`default_nettype wire

// ==== hw/spi_mux_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_mux_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     sck,
  input  logic                     cs_n,
  input  logic                     mosi,
  input  logic                     special_n,
  input  spi_mux_pkg::periph_vec_t periph_miso,
  output logic                     miso,
  output spi_mux_pkg::periph_vec_t periph_cs_n,
  output logic                     periph_sck,
  output logic                     periph_mosi,
  output spi_mux_pkg::reg_data_t   led,
  output spi_mux_pkg::dac_ctrl_t   dac_ctrl
);

  import spi_mux_pkg::*;

  //////////////////////////////
  // internal nets

  logic        rd_req;
  reg_addr_t   rd_addr;
  logic        wr_en;
  reg_frame_t  wr_frame;
  reg_data_t   rd_data;
  periph_vec_t mux_sel;
  logic        spi_dout;  // register bank miso before the router

  spi_frame_shifter u_shifter (
    .clk       (clk),
    .rst_n     (rst_n),
    .sck       (sck),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .special_n (special_n),
    .rd_data   (rd_data),
    .rd_req    (rd_req),
    .rd_addr   (rd_addr),
    .wr_en     (wr_en),
    .wr_frame  (wr_frame),
    .spi_dout  (spi_dout)
  );

  reg_bank u_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_req   (rd_req),
    .wr_en    (wr_en),
    .rd_addr  (rd_addr),
    .wr_frame (wr_frame),
    .rd_data  (rd_data),
    .mux_sel  (mux_sel),
    .led      (led),
    .dac_ctrl (dac_ctrl)
  );

  // raw pins here, router has no clk
  periph_router u_router (
    .cs_n        (cs_n),
    .special_n   (special_n),
    .sck         (sck),
    .mosi        (mosi),
    .spi_dout    (spi_dout),
    .mux_sel     (mux_sel),
    .periph_miso (periph_miso),
    .periph_cs_n (periph_cs_n),
    .periph_sck  (periph_sck),
    .periph_mosi (periph_mosi),
    .miso        (miso)
  );

endmodule

`default_nettype wire

// ==== sim/spi_mux_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_mux_tb;

  import spi_mux_pkg::*;

  //////////////////////////////
  // run length

  // bits per test group, in sequence order
  localparam int TOTAL_BITS  = 2*8 + 4*16 + 4*16 + 15 + 17 + 4*(16+16) + 50*16;
  localparam int N_FRAMES    = 2 + 4 + 4 + 2 + 8 + 50;
  localparam int HALF_CLKS   = 8;  // sck half period in clk cycles
  localparam int CYCLE_LIMIT = TOTAL_BITS * 2 * HALF_CLKS + N_FRAMES * 40 + 500;

  logic        clk;
  logic        rst_n;
  logic        sck;
  logic        cs_n;
  logic        mosi;
  logic        special_n;
  periph_vec_t periph_miso;
  logic        miso;
  periph_vec_t periph_cs_n;
  logic        periph_sck;
  logic        periph_mosi;
  reg_data_t   led;
  dac_ctrl_t   dac_ctrl;

  integer      seed;
  int          err_cnt   = 0;
  int          chk_cnt   = 0;
  int          cycle_cnt = 0;
  logic        chk_en;  // continuous checks armed once out of reset

  // reference register state
  reg_data_t   model_led;
  periph_vec_t model_mux;
  dac_ctrl_t   model_dac;

  spi_mux_top UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .sck         (sck),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .special_n   (special_n),
    .periph_miso (periph_miso),
    .miso        (miso),
    .periph_cs_n (periph_cs_n),
    .periph_sck  (periph_sck),
    .periph_mosi (periph_mosi),
    .led         (led),
    .dac_ctrl    (dac_ctrl)
  );

  always #20 clk = ~clk;  // 40 ns period

  //////////////////////////////
  // reference model

  // what the bank returns for an address, unmapped reads zero
  function automatic reg_data_t ref_read(input reg_addr_t a);
    reg_data_t r;
    case (a)
      ADDR_LED: r = model_led;
      ADDR_MUX: r = reg_data_t'(model_mux);
      ADDR_DAC: r = reg_data_t'(model_dac);  // 4 bits, upper zero
      default:  r = '0;
    endcase
    return r;
  endfunction

  task automatic model_write(input reg_addr_t a, input reg_data_t d);
    case (a)
      ADDR_LED: model_led = d;
      ADDR_MUX: model_mux = periph_vec_t'(d);
      ADDR_DAC: model_dac = d[3:0];  // ldac, reset, uni/bip a and b
      default:  ;                    // unknown address is dropped
    endcase
  endtask

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    chk_cnt++;
    if (exp !== act)
    begin
      err_cnt++;
      $display("mismatch %s: expected %0h actual %0h at %0t", name, exp, act, $time);
    end
  endtask

  //////////////////////////////
  // spi master

  // leaves us 2 ns past a rising clk edge
  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  // mode 0, msb first, miso captured right at each sck rise
  task automatic spi_frame(input logic special, input int n_bits, input logic [31:0] bits,
                           output logic [31:0] rx);
    int i;
    rx        = '0;
    special_n = ~special;  // settles before cs_n falls
    wait_clks(2);
    cs_n = 1'b0;
    wait_clks(HALF_CLKS);
    for (i = n_bits - 1; i >= 0; i--)
    begin
      mosi        = bits[i];
      periph_miso = periph_vec_t'($random(seed));  // fresh lane data every bit
      wait_clks(HALF_CLKS);
      rx  = {rx[30:0], miso};
      sck = 1'b1;
      wait_clks(HALF_CLKS);
      sck = 1'b0;
    end
    wait_clks(HALF_CLKS);
    cs_n = 1'b1;
    wait_clks(4);  // write lands on this edge
    special_n = 1'b1;
  endtask

  // one exact-length register frame, read-back checked against the model
  task automatic reg_access(input string name, input reg_addr_t a, input reg_data_t d);
    reg_frame_t  f;
    reg_data_t   exp_rd;
    logic [31:0] rx;
    f.addr = a;
    f.data = d;
    exp_rd = ref_read(a);  // value before this frame's own write
    spi_frame(1'b1, FRAME_BITS, 32'(f), rx);
    model_write(a, d);
    compare({name, " addr byte"}, 32'd0, 32'(rx[15:8]));  // miso low while address shifts
    compare({name, " read"}, 32'(exp_rd), 32'(rx[7:0]));
  endtask

  task automatic normal_frame(input int n_bits);
    logic [31:0] bits;
    logic [31:0] rx;
    bits = $random(seed);
    spi_frame(1'b0, n_bits, bits, rx);
  endtask

  //////////////////////////////
  // continuous compare

  // negedge keeps us clear of both the dut edge and the 2 ns drive point
  always @(negedge clk)
  begin
    periph_vec_t exp_sel;
    if (chk_en)
    begin
      compare("led", 32'(model_led), 32'(led));
      compare("dac_ctrl", 32'(model_dac), 32'(dac_ctrl));
      compare("periph_sck", 32'(sck), 32'(periph_sck));     // straight through
      compare("periph_mosi", 32'(mosi), 32'(periph_mosi));
      if (!special_n || cs_n)
        exp_sel = '1;          // nobody selected
      else
        exp_sel = ~model_mux;  // enabled lanes follow cs_n
      compare("periph_cs_n", 32'(exp_sel), 32'(periph_cs_n));
      if (special_n)
        compare("miso or", 32'(|(periph_miso & model_mux)), 32'(miso));
    end
  end

  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt == CYCLE_LIMIT)
    begin
      $display("timeout: test sequence did not end within %0d clk cycles", CYCLE_LIMIT);
      $display("Simulation FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // test sequence

  initial
  begin
    logic [31:0] rx;
    logic [31:0] bits;
    reg_addr_t   a;
    int          i;
    seed        = 32'h0a0c_4663;
    clk         = 1'b0;
    rst_n       = 1'b0;
    sck         = 1'b0;
    cs_n        = 1'b1;
    mosi        = 1'b0;
    special_n   = 1'b1;
    periph_miso = '0;
    chk_en      = 1'b0;
    model_led   = '0;
    model_mux   = '0;
    model_dac   = '0;
    wait_clks(10);
    rst_n  = 1'b1;
    chk_en = 1'b1;

    // reset state, cs_n toggling with mux cleared
    compare("reset led", 32'd0, 32'(led));
    compare("reset dac_ctrl", 32'd0, 32'(dac_ctrl));
    compare("reset selects", 32'hff, 32'(periph_cs_n));
    normal_frame(8);
    normal_frame(8);

    // writes to each register plus one unmapped
    reg_access("wr led", ADDR_LED, 8'ha5);
    compare("led value", 32'ha5, 32'(led));
    reg_access("wr mux", ADDR_MUX, 8'h5a);
    reg_access("wr dac", ADDR_DAC, 8'hf6);
    compare("dac low nibble", 32'h6, 32'(dac_ctrl));
    reg_access("wr unmapped", 8'h42, 8'hff);

    // read-back of each, unmapped gives zero
    reg_access("rd led", ADDR_LED, 8'h3c);
    reg_access("rd mux", ADDR_MUX, 8'h00);
    reg_access("rd dac", ADDR_DAC, 8'h09);
    reg_access("rd unmapped", 8'hc3, 8'h10);  // ends on a 0 bit for the short frame

    // wrong length frames are dropped
    bits = 32'({ADDR_LED, 8'hff});
    // low 15 bits of an led write, so a committed short frame would hit led
    spi_frame(1'b1, 15, bits, rx);
    compare("15 bit frame led", 32'h3c, 32'(led));
    spi_frame(1'b1, 17, {bits[30:0], 1'b1}, rx);
    compare("17 bit frame led", 32'h3c, 32'(led));

    // random mux, then a normal frame through it
    for (i = 0; i < 4; i++)
    begin
      reg_access("mux set", ADDR_MUX, reg_data_t'($random(seed)));
      normal_frame(16);
    end

    // mixed traffic
    for (i = 0; i < 50; i++)
    begin
      rx = $random(seed);
      case (rx[1:0])
        2'd0:    a = ADDR_LED;
        2'd1:    a = ADDR_MUX;
        2'd2:    a = ADDR_DAC;
        default: a = rx[15:8];  // mostly unmapped
      endcase
      reg_access("random frame", a, rx[31:24]);
    end

    wait_clks(4);
    $display("checks: %0d  errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
hw/spi_mux_pkg.sv
hw/spi_frame_shifter.sv
hw/reg_bank.sv
hw/periph_router.sv
hw/spi_mux_top.sv
sim/spi_mux_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the spi mux testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

# compile then run, log kept for the result search
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f list.f --top-module spi_mux_tb --Mdir obj_dir -o spi_mux_sim \
  && ./obj_dir/spi_mux_sim > "$LOG" 2>&1 \
  || echo "build or simulation stopped with an error"

cat "$LOG" 2>/dev/null

grep -q "Simulation PASSED" "$LOG" && echo "result: pass" && exit 0 \
  || { echo "result: fail"; exit 1; }
